// ==== rtl/fetch_pkg.sv ====
/*
 * Instruction fetch shared definitions
 * Widths, redirect source codes and the fetched word view
 */

`default_nettype none

package fetch_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Address and instruction word width
  localparam int XLEN     = 32;
  // Trap vector base, upper bits of mtvec
  localparam int MTVEC_W  = 25;
  // Interrupt index used for vectored traps
  localparam int IRQ_ID_W = 5;
  // Redirect source select
  localparam int PC_MUX_W = 3;

  ////////////////////////////////////////////////////////////
  // Redirect source codes
  ////////////////////////////////////////////////////////////

  localparam logic [PC_MUX_W-1:0] PC_BOOT     = 3'd0;
  localparam logic [PC_MUX_W-1:0] PC_JUMP     = 3'd1;
  localparam logic [PC_MUX_W-1:0] PC_BRANCH   = 3'd2;
  localparam logic [PC_MUX_W-1:0] PC_MRET     = 3'd3;
  localparam logic [PC_MUX_W-1:0] PC_DRET     = 3'd4;
  // Synchronous exception, jumps to mtvec base
  localparam logic [PC_MUX_W-1:0] PC_TRAP_EXC = 3'd5;
  // Interrupt, vectored by irq index
  localparam logic [PC_MUX_W-1:0] PC_TRAP_IRQ = 3'd6;
  // Debug halt entry
  localparam logic [PC_MUX_W-1:0] PC_TRAP_DBD = 3'd7;

  ////////////////////////////////////////////////////////////
  // Fetched word views
  ////////////////////////////////////////////////////////////

  // Full 32-bit word, or two 16-bit parcels
  // parcel[0] is the low parcel, parcel[1] the high one
  typedef union packed {
    logic [XLEN-1:0]  word;
    logic [1:0][15:0] parcel;
  } instr_word_u;

endpackage

`default_nettype wire

// ==== rtl/pc_select.sv ====
/*
 * Fetch target selection
 * Decodes the redirect source into a word-aligned fetch address
 */

`timescale 1ns/100ps
`default_nettype none

module pc_select import fetch_pkg::*; (
  input  wire logic [XLEN-1:0]     boot_addr_i,
  input  wire logic [XLEN-1:0]     jump_target_i,
  input  wire logic [XLEN-1:0]     branch_target_i,
  input  wire logic [XLEN-1:0]     mepc_i,
  input  wire logic [XLEN-1:0]     dpc_i,
  input  wire logic [XLEN-1:0]     dm_halt_addr_i,
  input  wire logic [MTVEC_W-1:0]  mtvec_addr_i,
  input  wire logic [IRQ_ID_W-1:0] irq_id_i,
  input  wire logic [PC_MUX_W-1:0] pc_mux_i,
  input  wire logic                pc_set_i,
  output logic      [XLEN-1:0]     branch_addr_o,
  output logic                     csr_mtvec_init_o
);

  // Raw target before alignment
  logic [XLEN-1:0] target;

  always_comb begin
    // Boot address as fallback
    target = boot_addr_i;
    unique case (pc_mux_i)
      PC_BOOT:     target = {boot_addr_i[XLEN-1:2], 2'b00};
      PC_JUMP:     target = jump_target_i;
      PC_BRANCH:   target = branch_target_i;
      PC_MRET:     target = mepc_i;
      PC_DRET:     target = dpc_i;
      // Exceptions all share the base address
      PC_TRAP_EXC: target = {mtvec_addr_i, 7'h00};
      // One word per interrupt line
      PC_TRAP_IRQ: target = {mtvec_addr_i, irq_id_i, 2'b00};
      PC_TRAP_DBD: target = {dm_halt_addr_i[XLEN-1:2], 2'b00};
      default:     target = boot_addr_i;
    endcase
  end

  // Every instruction sits on a word boundary
  assign branch_addr_o = {target[XLEN-1:2], 2'b00};

  // mtvec gets its reset value from the boot redirect
  assign csr_mtvec_init_o = pc_set_i && (pc_mux_i == PC_BOOT);

endmodule

`default_nettype wire

// ==== rtl/prefetch_ctrl.sv ====
/*
 * Prefetch control
 * Issues sequential word fetches within buffer credit and
 * drops responses that belong to a stale fetch stream
 */

`timescale 1ns/100ps
`default_nettype none

module prefetch_ctrl import fetch_pkg::*; #(
  parameter  int FIFO_DEPTH = 3,
  localparam int CNT_W      = $clog2(FIFO_DEPTH + 1)
) (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             pc_set_i,
  input  wire logic [XLEN-1:0]  branch_addr_i,
  input  wire logic             fetch_rvalid_i,
  input  wire logic [CNT_W-1:0] fifo_count_i,
  output logic                  fetch_req_o,
  output logic      [XLEN-1:0]  fetch_addr_o,
  output logic                  push_o,
  output logic      [XLEN-1:0]  push_addr_o,
  output logic                  flush_o
);

  // Discard counter covers several redirects worth of in-flight requests
  localparam int DISC_W = CNT_W + 2;

  logic              active_q;
  logic [XLEN-1:0]   fetch_addr_q;
  logic [XLEN-1:0]   resp_addr_q;
  logic [CNT_W-1:0]  outst_q;
  logic [DISC_W-1:0] discard_q;
  logic              credit;
  logic              keep;

  ////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////

  // Kept requests plus buffered words must leave room for one more
  assign credit = ({1'b0, outst_q} + {1'b0, fifo_count_i}) < (CNT_W + 1)'(FIFO_DEPTH);

  // No request in the redirect cycle, the new stream starts next cycle
  assign fetch_req_o  = active_q && credit && !pc_set_i;
  assign fetch_addr_o = fetch_addr_q;

  ////////////////////////////////////////////////////////////
  // Response side
  ////////////////////////////////////////////////////////////

  // Oldest responses are stale while discards are pending
  assign keep        = fetch_rvalid_i && (discard_q == '0);
  assign push_o      = keep && !pc_set_i;
  assign push_addr_o = resp_addr_q;
  // Buffer empties on the same edge as the redirect
  assign flush_o     = pc_set_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q  <= 1'b0;
      outst_q   <= '0;
      discard_q <= '0;
    end else if (pc_set_i) begin
      active_q  <= 1'b1;
      outst_q   <= '0;
      // Everything in flight now belongs to the old stream
      discard_q <= discard_q + DISC_W'(outst_q) - DISC_W'(fetch_rvalid_i);
    end else begin
      outst_q   <= outst_q + CNT_W'(fetch_req_o) - CNT_W'(keep);
      if (fetch_rvalid_i && !keep) begin
        discard_q <= discard_q - 1'b1;
      end
    end
  end

  // Addresses of the next request and of the oldest kept response
  always_ff @(posedge clk) begin
    if (pc_set_i) begin
      fetch_addr_q <= branch_addr_i;
      resp_addr_q  <= branch_addr_i;
    end else begin
      if (fetch_req_o) begin
        fetch_addr_q <= fetch_addr_q + XLEN'(4);
      end
      if (keep) begin
        resp_addr_q <= resp_addr_q + XLEN'(4);
      end
    end
  end

  // Memory answers only what was asked
  a_no_orphan_resp: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_rvalid_i |-> (outst_q != '0) || (discard_q != '0))
    else $error("fetch response with no request outstanding");

endmodule

`default_nettype wire

// ==== rtl/fetch_fifo.sv ====
/*
 * Fetch response buffer
 * Circular buffer of fetched words with address and bus error
 */

`timescale 1ns/100ps
`default_nettype none

module fetch_fifo import fetch_pkg::*; #(
  parameter  int FIFO_DEPTH = 3,
  localparam int CNT_W      = $clog2(FIFO_DEPTH + 1)
) (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             push_i,
  input  wire logic [XLEN-1:0]  push_addr_i,
  input  wire logic [XLEN-1:0]  push_data_i,
  input  wire logic             push_err_i,
  input  wire logic             pop_i,
  input  wire logic             flush_i,
  output logic      [CNT_W-1:0] count_o,
  output logic                  head_valid_o,
  output logic      [XLEN-1:0]  head_addr_o,
  output logic      [XLEN-1:0]  head_data_o,
  output logic                  head_err_o
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  // Storage
  logic [XLEN-1:0]  addr_q [FIFO_DEPTH];
  logic [XLEN-1:0]  data_q [FIFO_DEPTH];
  logic             err_q  [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  // Pointer control, flush wins over a push
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(push_i) - CNT_W'(pop_i);
    end
  end

  always_ff @(posedge clk) begin
    if (push_i && !flush_i) begin
      addr_q[wr_ptr_q] <= push_addr_i;
      data_q[wr_ptr_q] <= push_data_i;
      err_q[wr_ptr_q]  <= push_err_i;
    end
  end

  assign count_o      = count_q;
  assign head_valid_o = (count_q != '0);
  assign head_addr_o  = addr_q[rd_ptr_q];
  assign head_data_o  = data_q[rd_ptr_q];
  assign head_err_o   = err_q[rd_ptr_q];

  // Prefetch credit keeps the buffer from overflowing
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    (push_i && !flush_i) |-> (count_q < CNT_W'(FIFO_DEPTH)))
    else $error("push into full fetch buffer");

  // Output stage pops only a present head
  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    pop_i |-> (count_q != '0))
    else $error("pop from empty fetch buffer");

endmodule

`default_nettype wire

// ==== rtl/if_id_register.sv ====
/*
 * IF/ID pipeline register
 * Holds one fetched item for decode, flags compressed words
 * and stalls under ID back-pressure
 */

`timescale 1ns/100ps
`default_nettype none

module if_id_register import fetch_pkg::*; (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            pc_set_i,
  input  wire logic            id_ready_i,
  input  wire logic            head_valid_i,
  input  wire logic [XLEN-1:0] head_addr_i,
  input  wire logic [XLEN-1:0] head_data_i,
  input  wire logic            head_err_i,
  output logic                 pop_o,
  output logic                 id_valid_o,
  output logic      [XLEN-1:0] id_pc_o,
  output logic      [XLEN-1:0] id_instr_o,
  output logic                 id_bus_err_o,
  output logic                 id_compressed_o,
  output logic      [15:0]     id_compressed_instr_o
);

  instr_word_u head_word;
  logic        head_compressed;
  logic        load;

  assign head_word = head_data_i;

  // 32-bit encodings have both low opcode bits set
  assign head_compressed = (head_word.parcel[0][1:0] != 2'b11);

  // Load when empty or when ID takes the current item
  // never while a redirect kills the stream
  assign load  = head_valid_i && (!id_valid_o || id_ready_i) && !pc_set_i;
  assign pop_o = load;

  ////////////////////////////////////////////////////////////
  // Valid and compressed parcel
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_o            <= 1'b0;
      id_compressed_instr_o <= '0;
    end else begin
      if (pc_set_i) begin
        id_valid_o <= 1'b0;
      end else if (load) begin
        id_valid_o <= 1'b1;
      end else if (id_ready_i) begin
        // Accepted with nothing behind it
        id_valid_o <= 1'b0;
      end
      // Parcel sticks until the next compressed word
      if (load && head_compressed) begin
        id_compressed_instr_o <= head_word.parcel[0];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Payload
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (load) begin
      id_pc_o         <= head_addr_i;
      id_instr_o      <= head_word.word;
      id_bus_err_o    <= head_err_i;
      id_compressed_o <= head_compressed;
    end
  end

  // Stalled item is frozen until ID takes it
  a_stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (id_valid_o && !id_ready_i && !pc_set_i) |=>
      id_valid_o && $stable(id_pc_o) && $stable(id_instr_o) &&
      $stable(id_bus_err_o) && $stable(id_compressed_o) &&
      $stable(id_compressed_instr_o))
    else $error("IF/ID output changed while stalled");

endmodule

`default_nettype wire

// ==== rtl/if_stage.sv ====
/*
 * Instruction fetch stage top level
 * Target select, prefetcher, response buffer and IF/ID register
 */

`timescale 1ns/100ps
`default_nettype none

module if_stage import fetch_pkg::*; #(
  parameter  int FIFO_DEPTH = 3,
  localparam int CNT_W      = $clog2(FIFO_DEPTH + 1)
) (
  input  wire logic                clk,
  input  wire logic                rst_n,
  // Redirect targets and control
  input  wire logic [XLEN-1:0]     boot_addr_i,
  input  wire logic [XLEN-1:0]     jump_target_i,
  input  wire logic [XLEN-1:0]     branch_target_i,
  input  wire logic [XLEN-1:0]     mepc_i,
  input  wire logic [XLEN-1:0]     dpc_i,
  input  wire logic [XLEN-1:0]     dm_halt_addr_i,
  input  wire logic [MTVEC_W-1:0]  mtvec_addr_i,
  input  wire logic [IRQ_ID_W-1:0] irq_id_i,
  input  wire logic [PC_MUX_W-1:0] pc_mux_i,
  input  wire logic                pc_set_i,
  // Instruction bus
  output logic                     fetch_req_o,
  output logic      [XLEN-1:0]     fetch_addr_o,
  input  wire logic                fetch_rvalid_i,
  input  wire logic [XLEN-1:0]     fetch_rdata_i,
  input  wire logic                fetch_err_i,
  // Decode side
  input  wire logic                id_ready_i,
  output logic                     id_valid_o,
  output logic      [XLEN-1:0]     id_pc_o,
  output logic      [XLEN-1:0]     id_instr_o,
  output logic                     id_bus_err_o,
  output logic                     id_compressed_o,
  output logic      [15:0]         id_compressed_instr_o,
  output logic                     csr_mtvec_init_o
);

  logic [XLEN-1:0]  branch_addr;
  logic [CNT_W-1:0] fifo_count;
  logic             push;
  logic [XLEN-1:0]  push_addr;
  logic             flush;
  logic             pop;
  logic             head_valid;
  logic [XLEN-1:0]  head_addr;
  logic [XLEN-1:0]  head_data;
  logic             head_err;

  pc_select i_pc_select (
    .boot_addr_i      (boot_addr_i),
    .jump_target_i    (jump_target_i),
    .branch_target_i  (branch_target_i),
    .mepc_i           (mepc_i),
    .dpc_i            (dpc_i),
    .dm_halt_addr_i   (dm_halt_addr_i),
    .mtvec_addr_i     (mtvec_addr_i),
    .irq_id_i         (irq_id_i),
    .pc_mux_i         (pc_mux_i),
    .pc_set_i         (pc_set_i),
    .branch_addr_o    (branch_addr),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  prefetch_ctrl #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_prefetch_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .pc_set_i       (pc_set_i),
    .branch_addr_i  (branch_addr),
    .fetch_rvalid_i (fetch_rvalid_i),
    .fifo_count_i   (fifo_count),
    .fetch_req_o    (fetch_req_o),
    .fetch_addr_o   (fetch_addr_o),
    .push_o         (push),
    .push_addr_o    (push_addr),
    .flush_o        (flush)
  );

  fetch_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_fetch_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .push_i       (push),
    .push_addr_i  (push_addr),
    .push_data_i  (fetch_rdata_i),
    .push_err_i   (fetch_err_i),
    .pop_i        (pop),
    .flush_i      (flush),
    .count_o      (fifo_count),
    .head_valid_o (head_valid),
    .head_addr_o  (head_addr),
    .head_data_o  (head_data),
    .head_err_o   (head_err)
  );

  if_id_register i_if_id_register (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .pc_set_i              (pc_set_i),
    .id_ready_i            (id_ready_i),
    .head_valid_i          (head_valid),
    .head_addr_i           (head_addr),
    .head_data_i           (head_data),
    .head_err_i            (head_err),
    .pop_o                 (pop),
    .id_valid_o            (id_valid_o),
    .id_pc_o               (id_pc_o),
    .id_instr_o            (id_instr_o),
    .id_bus_err_o          (id_bus_err_o),
    .id_compressed_o       (id_compressed_o),
    .id_compressed_instr_o (id_compressed_instr_o)
  );

endmodule

`default_nettype wire

// ==== verification/tb_if_stage.sv ====
/*
 * Instruction fetch stage testbench
 * Random redirects, memory latency and ID stalls checked against a model
 */

`timescale 1ns/100ps
`default_nettype none

module tb_if_stage import fetch_pkg::*; ();

  localparam int FIFO_DEPTH      = 3;
  localparam int CLK_PERIOD      = 8;
  localparam int N_ITEMS         = 400;
  localparam int WATCHDOG_CYCLES = N_ITEMS * 20;

  logic                clk;
  logic                rst_n;
  logic [XLEN-1:0]     boot_addr_i;
  logic [XLEN-1:0]     jump_target_i;
  logic [XLEN-1:0]     branch_target_i;
  logic [XLEN-1:0]     mepc_i;
  logic [XLEN-1:0]     dpc_i;
  logic [XLEN-1:0]     dm_halt_addr_i;
  logic [MTVEC_W-1:0]  mtvec_addr_i;
  logic [IRQ_ID_W-1:0] irq_id_i;
  logic [PC_MUX_W-1:0] pc_mux_i;
  logic                pc_set_i;
  logic                fetch_req_o;
  logic [XLEN-1:0]     fetch_addr_o;
  logic                fetch_rvalid_i;
  logic [XLEN-1:0]     fetch_rdata_i;
  logic                fetch_err_i;
  logic                id_ready_i;
  logic                id_valid_o;
  logic [XLEN-1:0]     id_pc_o;
  logic [XLEN-1:0]     id_instr_o;
  logic                id_bus_err_o;
  logic                id_compressed_o;
  logic [15:0]         id_compressed_instr_o;
  logic                csr_mtvec_init_o;

  // Model state
  logic [31:0]     rng_state;
  logic [XLEN-1:0] req_addr_q [$];
  int              req_due_q [$];
  int              cycle;
  int              last_due;
  int              n_acc;
  int              n_redirect;
  bit              started;
  bit              prev_set;
  bit              prev_stall;
  // Next presented item is a fresh load
  bit              fresh;
  logic [XLEN-1:0] set_target;
  logic [XLEN-1:0] exp_pc;
  logic [XLEN-1:0] exp_fetch;
  logic [15:0]     exp_cparcel;
  logic [XLEN-1:0] prev_pc;
  logic [XLEN-1:0] prev_instr;
  logic            prev_err;
  logic            prev_comp;

  if_stage #(.FIFO_DEPTH(FIFO_DEPTH)) i_if_stage (.*);

  ////////////////////////////////////////////////////////////
  // Random numbers and memory contents
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = lcg_step(rng_state);
    return rng_state;
  endfunction

  // Halves swapped so the opcode bits come from well mixed upper bits
  function automatic logic [XLEN-1:0] mem_word(input logic [XLEN-1:0] addr);
    logic [31:0] h;
    h = lcg_step(lcg_step(addr ^ 32'h9e3779b9));
    return {h[15:0], h[31:16]};
  endfunction

  function automatic logic mem_err(input logic [XLEN-1:0] addr);
    return addr[6:4] == 3'b101;
  endfunction

  // Redirect target rules, always word aligned
  function automatic logic [XLEN-1:0] redirect_target(input logic [PC_MUX_W-1:0] code);
    logic [XLEN-1:0] t;
    case (code)
      PC_BOOT:     t = boot_addr_i;
      PC_JUMP:     t = jump_target_i;
      PC_BRANCH:   t = branch_target_i;
      PC_MRET:     t = mepc_i;
      PC_DRET:     t = dpc_i;
      PC_TRAP_EXC: t = {mtvec_addr_i, 7'b0000000};
      PC_TRAP_IRQ: t = {mtvec_addr_i, irq_id_i, 2'b00};
      default:     t = dm_halt_addr_i;
    endcase
    return t & ~32'h3;
  endfunction

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else abort_run($sformatf("mismatch %s: got 0x%08h expected 0x%08h", name, got, exp));
  endtask

  ////////////////////////////////////////////////////////////
  // Per-cycle drive and sample
  ////////////////////////////////////////////////////////////

  task automatic drive_cycle(input bit idle);
    logic [31:0] r;
    r          = next_rand();
    pc_set_i   = idle ? 1'b0 : (!started || r[31:28] == 4'hf);
    pc_mux_i   = r[22:20];
    id_ready_i = (r[27:26] != 2'b00);
    if (pc_set_i) begin
      // Boot first, then each code once, then random codes
      if (n_redirect == 0) begin
        pc_mux_i = PC_BOOT;
      end else if (n_redirect <= 8) begin
        pc_mux_i = PC_MUX_W'(n_redirect - 1);
      end
      boot_addr_i     = next_rand();
      jump_target_i   = next_rand();
      branch_target_i = next_rand();
      mepc_i          = next_rand();
      dpc_i           = next_rand();
      dm_halt_addr_i  = next_rand();
      r               = next_rand();
      mtvec_addr_i    = r[31:7];
      // Independent of the mtvec base bits
      r               = next_rand();
      irq_id_i        = r[31:27];
      set_target      = redirect_target(pc_mux_i);
      n_redirect++;
    end
    // In-order memory response once its latency has passed
    if (req_due_q.size() != 0 && req_due_q[0] <= cycle) begin
      fetch_rvalid_i = 1'b1;
      fetch_rdata_i  = mem_word(req_addr_q[0]);
      fetch_err_i    = mem_err(req_addr_q[0]);
      void'(req_addr_q.pop_front());
      void'(req_due_q.pop_front());
    end else begin
      fetch_rvalid_i = 1'b0;
      fetch_rdata_i  = '0;
      fetch_err_i    = 1'b0;
    end
  endtask

  task automatic sample_cycle();
    instr_word_u w;
    int          lat;
    check_eq("csr_mtvec_init_o", 32'(csr_mtvec_init_o), 32'(pc_set_i && pc_mux_i == PC_BOOT));
    if (!started) begin
      check_eq("fetch_req_o", 32'(fetch_req_o), 32'd0);
      check_eq("id_valid_o", 32'(id_valid_o), 32'd0);
    end
    // New stream requests one cycle after the redirect
    if (prev_set && !pc_set_i) begin
      check_eq("fetch_req_o", 32'(fetch_req_o), 32'd1);
    end
    if (fetch_req_o) begin
      check_eq("fetch_addr_o", fetch_addr_o, exp_fetch);
      exp_fetch = exp_fetch + 32'd4;
      lat       = 1 + int'(next_rand() >> 30);
      last_due  = (cycle + lat > last_due) ? cycle + lat : last_due + 1;
      req_addr_q.push_back(fetch_addr_o);
      req_due_q.push_back(last_due);
    end
    // Frozen while ID stalls
    if (prev_stall) begin
      check_eq("id_valid_o", 32'(id_valid_o), 32'd1);
      check_eq("id_pc_o", id_pc_o, prev_pc);
      check_eq("id_instr_o", id_instr_o, prev_instr);
      check_eq("id_bus_err_o", 32'(id_bus_err_o), 32'(prev_err));
      check_eq("id_compressed_o", 32'(id_compressed_o), 32'(prev_comp));
    end
    if (id_valid_o) begin
      w.word = mem_word(exp_pc);
      // Parcel register follows every loaded compressed word
      if (fresh && w.parcel[0][1:0] != 2'b11) begin
        exp_cparcel = w.parcel[0];
      end
      check_eq("id_pc_o", id_pc_o, exp_pc);
      check_eq("id_instr_o", id_instr_o, w.word);
      check_eq("id_bus_err_o", 32'(id_bus_err_o), 32'(mem_err(exp_pc)));
      check_eq("id_compressed_o", 32'(id_compressed_o), 32'(w.parcel[0][1:0] != 2'b11));
      check_eq("id_compressed_instr_o", 32'(id_compressed_instr_o), 32'(exp_cparcel));
      if (id_ready_i) begin
        exp_pc = exp_pc + 32'd4;
        n_acc++;
      end
    end
    fresh      = !id_valid_o || id_ready_i || pc_set_i;
    prev_stall = id_valid_o && !id_ready_i && !pc_set_i;
    prev_pc    = id_pc_o;
    prev_instr = id_instr_o;
    prev_err   = id_bus_err_o;
    prev_comp  = id_compressed_o;
    prev_set   = pc_set_i;
    // Old stream items must never show up after this
    if (pc_set_i) begin
      started   = 1'b1;
      exp_pc    = set_target;
      exp_fetch = set_target;
    end
  endtask

  task automatic step_cycle(input bit idle);
    @(posedge clk);
    cycle++;
    #1;
    drive_cycle(idle);
    @(negedge clk);
    sample_cycle();
  endtask

  ////////////////////////////////////////////////////////////
  // Clock, watchdog and main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    abort_run("timeout: the planned number of items was not accepted in time");
  end

  initial begin
    rng_state       = 32'h477831b8;
    rst_n           = 1'b0;
    boot_addr_i     = '0;
    jump_target_i   = '0;
    branch_target_i = '0;
    mepc_i          = '0;
    dpc_i           = '0;
    dm_halt_addr_i  = '0;
    mtvec_addr_i    = '0;
    irq_id_i        = '0;
    pc_mux_i        = '0;
    pc_set_i        = 1'b0;
    fetch_rvalid_i  = 1'b0;
    fetch_rdata_i   = '0;
    fetch_err_i     = 1'b0;
    id_ready_i      = 1'b0;
    cycle           = 0;
    last_due        = 0;
    n_acc           = 0;
    n_redirect      = 0;
    started         = 1'b0;
    prev_set        = 1'b0;
    prev_stall      = 1'b0;
    fresh           = 1'b1;
    set_target      = '0;
    exp_pc          = '0;
    exp_fetch       = '0;
    exp_cparcel     = '0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // Nothing may move before the first redirect
    repeat (3) step_cycle(1'b1);
    while (n_acc < N_ITEMS) begin
      step_cycle(1'b0);
    end
    assert (n_redirect > 8)
      else abort_run("not every pc mux code was used for a redirect");
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
rtl/fetch_pkg.sv
rtl/pc_select.sv
rtl/prefetch_ctrl.sv
rtl/fetch_fifo.sv
rtl/if_id_register.sv
rtl/if_stage.sv
verification/tb_if_stage.sv

// ==== Makefile ====
TOP = tb_if_stage
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f all.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
